// File: tb.f
verilog/sfu_pkg.sv
verilog/sfu_operand_classify.sv
verilog/sfu_seed_rom.sv
verilog/sfu_newton_step.sv
verilog/sfu_result_pack.sv
verilog/sfu_top.sv
sim/sfu_chk.sv
sim/sfu_tb.sv

// File: Bender.yml
package:
  name: sfu

sources:
  # Design, package first
  - verilog/sfu_pkg.sv
  - verilog/sfu_operand_classify.sv
  - verilog/sfu_seed_rom.sv
  - verilog/sfu_newton_step.sv
  - verilog/sfu_result_pack.sv
  - verilog/sfu_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/sfu_chk.sv
      - sim/sfu_tb.sv

// File: sim/sfu_tb.sv
/*
 * Directed testbench for the special function unit.
 * Each test task issues operations on the falling edge, then waits for the
 * pipeline to drain. A monitor checks every result in issue order against
 * the IEEE special-case rules or a real-number model, along with the error
 * flag and the four-cycle latency. A watchdog bounds the run.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_tb;

    import sfu_pkg::*;

    // ==============================
    // Run constants
    // ==============================

    localparam int  CLK_PERIOD   = 4;
    localparam int  RESET_CYCLES = 3;
    localparam int  LATENCY      = 4;                    // Valid in to valid out
    localparam int  N_RANDOM     = 200;                  // Accuracy sweep length
    localparam int  N_STREAM     = 40;
    localparam int  TOTAL_OPS    = 6 + 6 + 18 + N_RANDOM + N_STREAM + 8;
    localparam real TOLERANCE    = 1.0 / 262144.0;       // 2^-18 relative

    localparam float_word_t QNAN    = 32'h7FC0_0000;
    localparam float_word_t POS_INF = 32'h7F80_0000;
    localparam float_word_t NEG_INF = 32'hFF80_0000;

    logic        clk;
    logic        rst_n;
    logic [2:0]  op;
    float_word_t operand;
    logic        valid_in;
    float_word_t result;
    logic        valid_out;
    logic        error_flag;

    integer seed;
    int     cycle = 0;           // Rising edges seen so far

    // Expected outcome per issued operation, front is the oldest
    float_word_t exp_word_q[$];
    real         exp_real_q[$];
    bit          near_q[$];      // Set when checked against the real model
    logic        exp_err_q[$];
    int          issue_q[$];     // Edge count in the cycle valid_in is high

    sfu_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .operand    (operand),
        .valid_in   (valid_in),
        .result     (result),
        .valid_out  (valid_out),
        .error_flag (error_flag)
    );

    bind sfu_top sfu_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .valid_out  (valid_out),
        .error_flag (error_flag),
        .result     (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ==============================
    // Reference math and checks
    // ==============================

    // Normal single precision word to real
    function automatic real word_to_real(input float_word_t w);
        real mag;
        mag = (1.0 + real'(w[22:0]) / 8388608.0) * (2.0 ** real'(int'(w[30:23]) - 127));
        return w[31] ? -mag : mag;
    endfunction

    // 2^k as a positive float word
    function automatic float_word_t pow2_word(input int k);
        float_word_t w;
        w        = 32'h0;
        w[30:23] = 8'(127 + k);
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input float_word_t expected,
                              input float_word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR t=%0t %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_near(input string name, input real expected,
                              input float_word_t actual);
        real rel;
        rel = (word_to_real(actual) - expected) / expected;
        if (rel < 0.0) begin
            rel = -rel;
        end
        if ($isunknown(actual) || rel > TOLERANCE) begin
            abort_run($sformatf("ERR t=%0t %s expected %g got %h (%g)",
                                $time, name, expected, actual, word_to_real(actual)));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR t=%0t %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic compare_latency(input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("ERR t=%0t valid_out latency expected %0d got %0d",
                                $time, expected, actual));
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : result_monitor
        float_word_t want_word;
        real         want_real;
        bit          want_near;
        logic        want_err;
        int          issued;
        if (valid_out === 1'b1 && exp_word_q.size() == 0) begin
            abort_run("valid_out rose with no operation outstanding");
        end else if (valid_out === 1'b1) begin
            want_word = exp_word_q.pop_front();
            want_real = exp_real_q.pop_front();
            want_near = near_q.pop_front();
            want_err  = exp_err_q.pop_front();
            issued    = issue_q.pop_front();
            compare_latency(LATENCY, cycle - issued);
            if (want_near) begin
                check_near("result", want_real, result);
            end else begin
                check_word("result", want_word, result);
            end
            check_flag("error_flag", want_err, error_flag);
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + TOTAL_OPS * 10) * CLK_PERIOD);
        abort_run("Watchdog timeout, the tests did not finish in time");
    end

    // ==============================
    // Stimulus
    // ==============================

    // Drive one operation for a single cycle, called on a falling edge
    task automatic issue(input logic [2:0] code, input float_word_t word, input bit near,
                         input float_word_t exp_word, input real exp_real, input logic exp_err);
        op       = code;
        operand  = word;
        valid_in = 1'b1;
        exp_word_q.push_back(exp_word);
        exp_real_q.push_back(exp_real);
        near_q.push_back(near);
        exp_err_q.push_back(exp_err);
        issue_q.push_back(cycle);      // Strobe is high in this cycle
        @(negedge clk);
        valid_in = 1'b0;               // Back-to-back issue raises it again
    endtask

    task automatic exact_op(input logic [2:0] code, input float_word_t word,
                            input float_word_t exp_word, input logic exp_err);
        issue(code, word, 1'b0, exp_word, 0.0, exp_err);
    endtask

    task automatic modelled_op(input sfu_op_t code, input float_word_t word);
        real x;
        x = word_to_real(word);
        issue(code, word, 1'b1, 32'h0, (code == SFU_RSQ) ? 1.0 / $sqrt(x) : 1.0 / x, 1'b0);
    endtask

    task automatic wait_drain();
        int idle;
        idle = 0;
        while (exp_word_q.size() > 0) begin
            @(negedge clk);
            idle++;
            if (idle > LATENCY + 2) begin
                abort_run("valid_out never came for an issued operation");
            end
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic rcp_special_cases();
        exact_op(SFU_RCP, 32'h0000_0000, POS_INF, 1'b1);
        exact_op(SFU_RCP, 32'h8000_0000, NEG_INF, 1'b1);
        exact_op(SFU_RCP, POS_INF, 32'h0000_0000, 1'b0);
        exact_op(SFU_RCP, NEG_INF, 32'h8000_0000, 1'b0);
        exact_op(SFU_RCP, 32'h7F80_0001, QNAN, 1'b0);     // Signalling NaN in
        exact_op(SFU_RCP, 32'h0000_0123, POS_INF, 1'b1);  // Denormal reads as +0
        wait_drain();
    endtask

    task automatic rsq_special_cases();
        exact_op(SFU_RSQ, 32'h0000_0000, POS_INF, 1'b1);
        exact_op(SFU_RSQ, 32'h8000_0000, POS_INF, 1'b1);
        exact_op(SFU_RSQ, 32'hBF80_0000, QNAN, 1'b1);     // -1.0
        exact_op(SFU_RSQ, NEG_INF, QNAN, 1'b1);
        exact_op(SFU_RSQ, POS_INF, 32'h0000_0000, 1'b0);
        exact_op(SFU_RSQ, 32'hFFC0_0001, QNAN, 1'b0);
        wait_drain();
    endtask

    // Zero mantissa hits a seed of exactly 1.0
    task automatic exact_powers();
        for (int k = -4; k <= 4; k++) begin
            exact_op(SFU_RCP, pow2_word(k), pow2_word(-k), 1'b0);
            exact_op(SFU_RSQ, pow2_word(2 * k), pow2_word(-k), 1'b0);
        end
        wait_drain();
    endtask

    task automatic random_accuracy();
        float_word_t w;
        for (int i = 0; i < N_RANDOM; i++) begin
            w[22:0]  = $random(seed);
            w[30:23] = 8'(2 + ($unsigned($random(seed)) % 249));  // 2 to 250
            if (i % 2 == 0) begin
                w[31] = $random(seed) & 1;  // RCP keeps the sign
                modelled_op(SFU_RCP, w);
            end else begin
                w[31] = 1'b0;
                modelled_op(SFU_RSQ, w);
            end
        end
        wait_drain();
    endtask

    // Distinct exact results expose any reordering
    task automatic streaming_order();
        int k;
        int gap;
        for (int i = 0; i < N_STREAM; i++) begin
            k   = int'($unsigned($random(seed)) % 41) - 20;
            gap = int'($unsigned($random(seed)) % 3);
            if ($random(seed) & 1) begin
                exact_op(SFU_RSQ, pow2_word(2 * k), pow2_word(-k), 1'b0);
            end else begin
                exact_op(SFU_RCP, pow2_word(k), pow2_word(-k), 1'b0);
            end
            repeat (gap) @(negedge clk);
        end
        wait_drain();
    endtask

    task automatic unsupported_and_underflow();
        for (int code = 2; code < 8; code++) begin
            exact_op(3'(code), 32'h3F80_0000, QNAN, 1'b1);
        end
        exact_op(SFU_RCP, 32'h7F00_0000, 32'h0000_0000, 1'b0);  // 1/2^127 is denormal
        exact_op(SFU_RCP, 32'hFF12_3456, 32'h8000_0000, 1'b0);
        wait_drain();
    endtask

    initial begin
        seed     = 94347;
        clk      = 1'b0;
        rst_n    = 1'b0;
        op       = 3'd0;
        operand  = 32'h0;
        valid_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        rcp_special_cases();
        rsq_special_cases();
        exact_powers();
        random_accuracy();
        streaming_order();
        unsupported_and_underflow();

        if (exp_word_q.size() != 0) begin
            abort_run("Results still outstanding at the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/sfu_chk.sv
/*
 * Concurrent assertions for the special function unit top level.
 * Bound to sfu_top from the testbench. Covers the fixed valid latency,
 * error flag qualification, known result bits and quiet outputs in reset.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 valid_in,
    input logic                 valid_out,
    input logic                 error_flag,
    input sfu_pkg::float_word_t result
);

    // ==============================
    // Pipeline timing
    // ==============================

    // Four stages, no stalls, checked once the window is clear of reset
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
            $past(rst_n, 4) |-> valid_out == $past(valid_in, 4)
    ) else $error("valid_out does not follow valid_in by 4 cycles");

    // ==============================
    // Output qualification
    // ==============================

    flag_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n) error_flag |-> valid_out
    ) else $error("error_flag high without valid_out");

    result_known: assert property (
        @(posedge clk) disable iff (!rst_n) valid_out |-> !$isunknown(result)
    ) else $error("result has unknown bits while valid_out is high");

    // Async reset clears the output strobe
    reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !valid_out
    ) else $error("valid_out high during reset");

endmodule

`default_nettype wire

// File: verilog/sfu_top.sv
/*
 * Special function unit top level.
 * Four-stage pipeline computing RCP and RSQ of single precision operands.
 * A strobe on valid_in issues one operation; the result appears with
 * valid_out four cycles later, in issue order, with no back-pressure.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2:0]           op,
    input  sfu_pkg::float_word_t operand,
    input  logic                 valid_in,
    output sfu_pkg::float_word_t result,
    output logic                 valid_out,
    output logic                 error_flag
);

    import sfu_pkg::*;

    // Classify to ROM
    table_index_t table_index;
    sfu_op_t      table_sel;
    seed_t        seed;

    // Stage 0 fields
    logic         s0_valid;
    sfu_op_t      s0_op;
    logic         s0_sign;
    logic [7:0]   s0_exp;
    logic [22:0]  s0_mant;
    logic         s0_special;
    float_word_t  s0_special_result;
    logic         s0_error;

    // Stage 2 fields
    logic         s2_valid;
    sfu_op_t      s2_op;
    logic         s2_sign;
    logic [7:0]   s2_exp;
    fraction_t    s2_refined;
    logic         s2_special;
    float_word_t  s2_special_result;
    logic         s2_error;

    sfu_operand_classify u_classify (
        .clk               (clk),
        .rst_n             (rst_n),
        .op                (op),
        .operand           (operand),
        .valid_in          (valid_in),
        .table_index       (table_index),
        .table_sel         (table_sel),
        .s0_valid          (s0_valid),
        .s0_op             (s0_op),
        .s0_sign           (s0_sign),
        .s0_exp            (s0_exp),
        .s0_mant           (s0_mant),
        .s0_special        (s0_special),
        .s0_special_result (s0_special_result),
        .s0_error          (s0_error)
    );

    sfu_seed_rom u_seed_rom (
        .clk         (clk),
        .table_index (table_index),
        .table_sel   (table_sel),
        .seed        (seed)
    );

    sfu_newton_step u_newton (
        .clk               (clk),
        .rst_n             (rst_n),
        .seed              (seed),
        .s0_valid          (s0_valid),
        .s0_op             (s0_op),
        .s0_sign           (s0_sign),
        .s0_exp            (s0_exp),
        .s0_mant           (s0_mant),
        .s0_special        (s0_special),
        .s0_special_result (s0_special_result),
        .s0_error          (s0_error),
        .s2_valid          (s2_valid),
        .s2_op             (s2_op),
        .s2_sign           (s2_sign),
        .s2_exp            (s2_exp),
        .s2_refined        (s2_refined),
        .s2_special        (s2_special),
        .s2_special_result (s2_special_result),
        .s2_error          (s2_error)
    );

    sfu_result_pack u_pack (
        .clk               (clk),
        .rst_n             (rst_n),
        .s2_valid          (s2_valid),
        .s2_op             (s2_op),
        .s2_sign           (s2_sign),
        .s2_exp            (s2_exp),
        .s2_refined        (s2_refined),
        .s2_special        (s2_special),
        .s2_special_result (s2_special_result),
        .s2_error          (s2_error),
        .result            (result),
        .valid_out         (valid_out),
        .error_flag        (error_flag)
    );

endmodule

`default_nettype wire

// File: verilog/sfu_result_pack.sv
/*
 * Stage 3 of the special function unit.
 * Normalizes the refined 2.23 fraction, forms the result exponent from
 * the operand exponent, flushes underflow to signed zero and lets a
 * flagged special result take over. Drives the unit outputs.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_result_pack (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 s2_valid,
    input  sfu_pkg::sfu_op_t     s2_op,
    input  logic                 s2_sign,
    input  logic [7:0]           s2_exp,
    input  sfu_pkg::fraction_t   s2_refined,
    input  logic                 s2_special,
    input  sfu_pkg::float_word_t s2_special_result,
    input  logic                 s2_error,
    output sfu_pkg::float_word_t result,
    output logic                 valid_out,
    output logic                 error_flag
);

    import sfu_pkg::*;

    logic signed [9:0] base_exp;   // Exponent for a refined value of 1.0
    logic signed [9:0] norm_exp;
    logic [9:0]        half_exp;   // Operand exponent halved, rounded up
    logic [22:0]       norm_mant;
    logic              res_sign;
    float_word_t       computed;

    assign half_exp = ({2'b00, s2_exp} + 10'd1) >> 1;
    assign res_sign = (s2_op == SFU_RCP) && s2_sign;  // RSQ is never negative

    always_comb begin
        if (s2_op == SFU_RSQ) begin
            base_exp = 10'(EXP_BIAS + (EXP_BIAS + 1) / 2) - half_exp;
        end else begin
            base_exp = 10'(2 * EXP_BIAS) - {2'b00, s2_exp};
        end

        if (s2_refined[23]) begin
            norm_exp  = base_exp;                     // Exactly 1.0
            norm_mant = s2_refined[22:0];
        end else if (s2_refined[22]) begin
            norm_exp  = base_exp - 10'sd1;            // In (0.5,1) so shift once
            norm_mant = {s2_refined[21:0], 1'b0};
        end else begin
            norm_exp  = base_exp - 10'sd1;            // Truncated just under 0.5
            norm_mant = 23'h0;
        end

        if (norm_exp <= 10'sd0) begin
            computed = {res_sign, 31'h0};             // Underflow to signed zero
        end else begin
            computed = {res_sign, norm_exp[7:0], norm_mant};
        end
    end

    always_ff @(posedge clk) begin
        result <= s2_special ? s2_special_result : computed;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            error_flag <= 1'b0;
        end else begin
            valid_out  <= s2_valid;
            error_flag <= s2_valid && s2_error;  // Only raised with a result
        end
    end

endmodule

`default_nettype wire

// File: verilog/sfu_newton_step.sv
/*
 * Stages 1 and 2 of the special function unit.
 * Stage 1 forms mantissa times seed for RCP or seed squared for RSQ.
 * Stage 2 applies one Newton-Raphson refinement and hands a 2.23
 * fraction to the packer. Side fields are delayed alongside.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_newton_step (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sfu_pkg::seed_t       seed,
    input  logic                 s0_valid,
    input  sfu_pkg::sfu_op_t     s0_op,
    input  logic                 s0_sign,
    input  logic [7:0]           s0_exp,
    input  logic [22:0]          s0_mant,
    input  logic                 s0_special,
    input  sfu_pkg::float_word_t s0_special_result,
    input  logic                 s0_error,
    output logic                 s2_valid,
    output sfu_pkg::sfu_op_t     s2_op,
    output logic                 s2_sign,
    output logic [7:0]           s2_exp,
    output sfu_pkg::fraction_t   s2_refined,
    output logic                 s2_special,
    output sfu_pkg::float_word_t s2_special_result,
    output logic                 s2_error
);

    import sfu_pkg::*;

    // ==============================
    // Stage 1
    // ==============================

    logic [23:0] mult_a;     // Mantissa for RCP, seed for RSQ
    logic [47:0] prod_full;  // 2.46 product
    logic [24:0] scaled_c;   // 2.23 mantissa, doubled for even RSQ exponent

    logic        s1_valid;
    sfu_op_t     s1_op;
    logic        s1_sign;
    logic [7:0]  s1_exp;
    seed_t       s1_seed;
    logic [24:0] s1_prod;    // a*x0 or x0^2 in 2.23
    logic [24:0] s1_scaled;
    logic        s1_special;
    float_word_t s1_special_result;
    logic        s1_error;

    assign mult_a    = (s0_op == SFU_RSQ) ? seed : {1'b1, s0_mant};
    assign prod_full = mult_a * seed;
    assign scaled_c  = (s0_op == SFU_RSQ && !s0_exp[0]) ? {1'b1, s0_mant, 1'b0}
                                                        : {2'b01, s0_mant};

    // ==============================
    // Stage 2
    // ==============================

    logic [49:0] ap_full;      // a * x0^2, 4.46
    logic [24:0] corr;         // 2 - a*x0 or 3 - a*x0^2
    logic [48:0] refine_full;  // x0 * corr, 3.46
    fraction_t   refined_c;

    assign ap_full = s1_scaled * s1_prod;

    always_comb begin
        if (s1_op == SFU_RSQ) begin
            corr      = 25'h180_0000 - ap_full[47:23];  // 3.0 minus product
            refine_full = s1_seed * corr;
            refined_c = refine_full[48:24];             // Extra shift halves it
        end else begin
            corr      = 25'h100_0000 - s1_prod;         // 2.0 minus product
            refine_full = s1_seed * corr;
            refined_c = refine_full[47:23];
        end
    end

    // Valid chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= s0_valid;
            s2_valid <= s1_valid;
        end
    end

    // Datapath and side fields
    always_ff @(posedge clk) begin
        s1_op             <= s0_op;
        s1_sign           <= s0_sign;
        s1_exp            <= s0_exp;
        s1_seed           <= seed;
        s1_prod           <= prod_full[47:23];
        s1_scaled         <= scaled_c;
        s1_special        <= s0_special;
        s1_special_result <= s0_special_result;
        s1_error          <= s0_error;

        s2_op             <= s1_op;
        s2_sign           <= s1_sign;
        s2_exp            <= s1_exp;
        s2_refined        <= refined_c;
        s2_special        <= s1_special;
        s2_special_result <= s1_special_result;
        s2_error          <= s1_error;
    end

endmodule

`default_nettype wire

// File: verilog/sfu_seed_rom.sv
/*
 * Seed tables for the RCP and RSQ Newton-Raphson steps.
 * Both tables are computed from real arithmetic at elaboration and
 * rounded to 23 fraction bits. The read is registered on the same edge
 * as stage 0, so the seed lines up with the stage 0 fields.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_seed_rom (
    input  logic                  clk,
    input  sfu_pkg::table_index_t table_index,
    input  sfu_pkg::sfu_op_t      table_sel,
    output sfu_pkg::seed_t        seed
);

    import sfu_pkg::*;

    seed_t rcp_table [TABLE_DEPTH];
    seed_t rsq_table [TABLE_DEPTH];

    // Reciprocal of the left edge of mantissa bucket idx
    function automatic seed_t rcp_entry(input int idx);
        real x;
        x = 1.0 + real'(idx) / real'(TABLE_DEPTH);
        return seed_t'(int'((1.0 / x) * 8388608.0));  // Scale by 2^23 and round
    endfunction

    // Upper half serves odd exponents on [1,2), lower half even ones on [2,4)
    function automatic seed_t rsq_entry(input int idx);
        int  j;
        real x;
        j = idx % (TABLE_DEPTH / 2);
        if (idx >= TABLE_DEPTH / 2) begin
            x = 1.0 + real'(j) / real'(TABLE_DEPTH / 2);
        end else begin
            x = 2.0 + 2.0 * real'(j) / real'(TABLE_DEPTH / 2);
        end
        return seed_t'(int'((1.0 / $sqrt(x)) * 8388608.0));
    endfunction

    initial begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            rcp_table[i] = rcp_entry(i);
            rsq_table[i] = rsq_entry(i);
        end
    end

    // Registered read, unsupported opcodes just get the RCP entry
    always_ff @(posedge clk) begin
        if (table_sel == SFU_RSQ) begin
            seed <= rsq_table[table_index];
        end else begin
            seed <= rcp_table[table_index];
        end
    end

endmodule

`default_nettype wire

// File: verilog/sfu_operand_classify.sv
/*
 * Stage 0 of the special function unit.
 * Splits the incoming float, spots zero, denormal, infinity, NaN and
 * negative operands, and picks the special result and error per opcode.
 * The table index is combinational and goes straight to the seed ROM,
 * while the operand fields are registered for the Newton step.
 */

`timescale 1ns/1ns
`default_nettype none

module sfu_operand_classify (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2:0]           op,
    input  sfu_pkg::float_word_t operand,
    input  logic                 valid_in,
    output sfu_pkg::table_index_t table_index,
    output sfu_pkg::sfu_op_t     table_sel,
    output logic                 s0_valid,
    output sfu_pkg::sfu_op_t     s0_op,
    output logic                 s0_sign,
    output logic [7:0]           s0_exp,
    output logic [22:0]          s0_mant,
    output logic                 s0_special,
    output sfu_pkg::float_word_t s0_special_result,
    output logic                 s0_error
);

    import sfu_pkg::*;

    // ==============================
    // Operand unpacking
    // ==============================

    logic        in_sign;
    logic [7:0]  in_exp;
    logic [22:0] in_mant;
    logic        is_zero;   // Zero or denormal
    logic        is_inf;
    logic        is_nan;
    logic        is_neg;    // Negative and not flushed to zero

    logic        special_c;
    float_word_t special_result_c;
    logic        error_c;

    assign in_sign = operand[31];
    assign in_exp  = operand[30:23];
    assign in_mant = operand[22:0];

    assign is_zero = (in_exp == 8'h00);  // Denormals flush to signed zero
    assign is_inf  = (in_exp == 8'hFF) && (in_mant == 23'h0);
    assign is_nan  = (in_exp == 8'hFF) && (in_mant != 23'h0);
    assign is_neg  = in_sign && !is_zero;  // Includes -Inf

    assign table_sel = sfu_op_t'(op);

    // RSQ covers [1,4) so the exponent parity selects the half of the table
    assign table_index = (table_sel == SFU_RSQ) ? {in_exp[0], in_mant[22:14]}
                                                : in_mant[22:13];

    // ==============================
    // Special operand decode
    // ==============================

    always_comb begin
        special_c        = 1'b0;
        special_result_c = QNAN_WORD;
        error_c          = 1'b0;
        case (table_sel)
            SFU_RCP: begin
                if (is_nan) begin
                    special_c = 1'b1;                  // NaN in, quiet NaN out
                end else if (is_zero) begin
                    special_c        = 1'b1;
                    special_result_c = in_sign ? NEG_INF_WORD : POS_INF_WORD;
                    error_c          = 1'b1;           // Divide by zero
                end else if (is_inf) begin
                    special_c        = 1'b1;
                    special_result_c = {in_sign, 31'h0};  // Signed zero
                end
            end
            SFU_RSQ: begin
                if (is_nan) begin
                    special_c = 1'b1;
                end else if (is_neg) begin
                    special_c = 1'b1;                  // Root of negative
                    error_c   = 1'b1;
                end else if (is_zero) begin
                    special_c        = 1'b1;
                    special_result_c = POS_INF_WORD;   // +Inf for either zero
                    error_c          = 1'b1;
                end else if (is_inf) begin
                    special_c        = 1'b1;
                    special_result_c = 32'h0000_0000;  // +Inf gives +0
                end
            end
            default: begin
                special_c = 1'b1;                      // Unsupported opcode
                error_c   = 1'b1;
            end
        endcase
    end

    // ==============================
    // Stage 0 registers
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_valid <= 1'b0;
        end else begin
            s0_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        s0_op             <= table_sel;
        s0_sign           <= in_sign;
        s0_exp            <= in_exp;
        s0_mant           <= in_mant;
        s0_special        <= special_c;
        s0_special_result <= special_result_c;
        s0_error          <= error_c;
    end

endmodule

`default_nettype wire

// File: verilog/sfu_pkg.sv
/*
 * Shared types and constants for the special function unit.
 * Defines the opcode enum, the float word, seed, index and fraction
 * types, and the IEEE special-value words used by the pipeline stages.
 * Each stage imports this package inside its module body.
 */

`default_nettype none

package sfu_pkg;

    // ==============================
    // Opcodes
    // ==============================

    // Only RCP and RSQ are implemented; codes 2 to 7 are rejected
    typedef enum logic [2:0] {
        SFU_RCP = 3'd0,  // Reciprocal
        SFU_RSQ = 3'd1   // Reciprocal square root
    } sfu_op_t;

    // ==============================
    // Data types
    // ==============================

    typedef logic [31:0] float_word_t;  // IEEE single precision word

    typedef logic [23:0] seed_t;         // Table seed in 1.23 fixed point

    typedef logic [9:0] table_index_t;  // Seed table address

    // Refined mantissa in 2.23 fixed point
    typedef logic [24:0] fraction_t;

    // ==============================
    // Constants
    // ==============================

    localparam int EXP_BIAS = 127;  // Single precision exponent bias

    localparam float_word_t QNAN_WORD    = 32'h7FC0_0000;  // Default quiet NaN
    localparam float_word_t POS_INF_WORD = 32'h7F80_0000;
    localparam float_word_t NEG_INF_WORD = 32'hFF80_0000;

    // Entries per seed table
    localparam int TABLE_DEPTH = 1024;

endpackage

`default_nettype wire
